//--- Makefile
# Verilator build and run for the Zemina 90-in-1 bank-switching unit

VERILATOR  ?= verilator
TB_TOP     ?= zemina90_tb
RTL_TOP    ?= zemina90_top
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= TEST PASS

.PHONY: all build sim lint clean

all: sim

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the pass line shows up in the simulation output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(RTL_TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/zemina90_assertions.sv
`timescale 1ns/1ps
`include "mapper_defines.svh"

module zemina90_assertions (
    input logic                     clk,
    input logic                     reset,
    input mapper_pkg::cpu_bus_t     cpu,
    input mapper_pkg::dev_sel_t     sel,
    input logic [`ZEMINA_SLOTS-1:0] slot_wr,
    input mapper_pkg::segment_t     data_to_mapper
);

    import mapper_pkg::*;

    int   fail_count = 0;  // Failed assertions so far
    logic sel_foreign;     // Selection names no existing Zemina slot

    assign sel_foreign = (sel.typ != DEV_ZEMINA90) || (int'(sel.num) >= `ZEMINA_SLOTS);

    strobe_qualified: assert property (@(posedge clk) disable iff (reset)
        (|slot_wr) |-> (cpu.req && cpu.iorq && cpu.wr && !cpu.m1))
    else begin
        fail_count++;
        $error("slot_wr %h high outside a qualified I/O write", slot_wr);
    end

    // The registered output shows 0xFF one edge later
    foreign_reads_ff: assert property (@(posedge clk) disable iff (reset)
        sel_foreign |=> (data_to_mapper == 8'hFF))
    else begin
        fail_count++;
        $error("data_to_mapper %h after a foreign selection", data_to_mapper);
    end

    output_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(data_to_mapper))
    else begin
        fail_count++;
        $error("data_to_mapper unknown");
    end

endmodule

bind zemina90_top zemina90_assertions assertions_i (
    .clk            (clk),
    .reset          (reset),
    .cpu            (cpu),
    .sel            (sel),
    .slot_wr        (slot_wr),
    .data_to_mapper (data_to_mapper)
);

//--- testbench/zemina90_tb.sv
`timescale 1ns/1ps
`include "mapper_defines.svh"

module zemina90_tb;

    import mapper_pkg::*;

    localparam int RESET_CYCLES  = 8;
    localparam int RESET_TIMEOUT = 50;    // Cycles allowed until reset is seen low
    localparam int MIX_CYCLES    = 3000;

    logic      clk;
    logic      reset;
    cpu_bus_t  cpu;
    io_entry_t io_table [`IO_TABLE_SIZE];
    dev_sel_t  sel;
    segment_t  data_to_mapper;

    logic [31:0] lcg_state;
    logic [7:0]  slot_port [`ZEMINA_SLOTS];     // I/O port of each Zemina slot
    segment_t    model_seg [`ZEMINA_SLOTS][4];  // Reference segment registers
    segment_t    expected;                      // Prediction for the last driven cycle
    logic        expect_valid;

    zemina90_top dut_i (
        .clk            (clk),
        .reset          (reset),
        .cpu            (cpu),
        .io_table       (io_table),
        .sel            (sel),
        .data_to_mapper (data_to_mapper)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Two LCG steps whose upper halves form the result
    function automatic logic [31:0] rand_bits();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        hi        = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic cpu_bus_t make_bus(input logic [15:0] addr, input logic [7:0] data,
                                          input logic wr, input logic iorq,
                                          input logic m1, input logic req);
        cpu_bus_t c;
        c.addr = addr;
        c.data = data;
        c.wr   = wr;
        c.iorq = iorq;
        c.m1   = m1;
        c.req  = req;
        return c;
    endfunction

    function automatic dev_sel_t zemina_sel(input slot_num_t n);
        dev_sel_t s;
        s.typ = DEV_ZEMINA90;
        s.num = n;
        return s;
    endfunction

    // Mode rule on the value byte with the page counted in 8 KB segments
    function automatic void model_write(input slot_num_t n, input logic [7:0] value);
        segment_t page;
        segment_t even_page;
        segment_t odd_page;
        page      = {1'b0, value[5:0], 1'b0};
        even_page = {page[7:2], 1'b0, page[0]};
        odd_page  = {page[7:2], 1'b1, page[0]};
        case (value[7:6])
            2'd2: begin  // 32 KB block
                model_seg[n][0] = even_page;
                model_seg[n][1] = even_page + 8'd1;
                model_seg[n][2] = odd_page;
                model_seg[n][3] = odd_page + 8'd1;
            end
            2'd3: begin
                model_seg[n][0] = page;
                model_seg[n][1] = page + 8'd1;
                model_seg[n][2] = page + 8'd1;
                model_seg[n][3] = page;
            end
            default: begin
                model_seg[n][0] = page;
                model_seg[n][1] = page + 8'd1;
                model_seg[n][2] = page;
                model_seg[n][3] = page + 8'd1;
            end
        endcase
    endfunction

    function automatic void model_bus(input cpu_bus_t c);
        if (c.req && c.iorq && c.wr && !c.m1) begin
            for (int s = 0; s < `ZEMINA_SLOTS; s++) begin
                if (c.addr[7:0] == slot_port[slot_num_t'(s)]) begin
                    model_write(slot_num_t'(s), c.data);
                end
            end
        end
    endfunction

    function automatic segment_t predict(input dev_sel_t s, input logic [15:0] addr);
        logic [15:0] offset;
        offset = addr - 16'h4000;  // Windows counted from the bottom of the banked range
        if (s.typ != DEV_ZEMINA90 || int'(s.num) >= `ZEMINA_SLOTS) begin
            return 8'hFF;
        end
        return model_seg[s.num][offset[14:13]];
    endfunction

    task automatic check_segment(input segment_t exp_val, input segment_t act_val);
        if (act_val !== exp_val) begin
            $display("** Error data_to_mapper: expected %h, got %h", exp_val, act_val);
            $display("TEST FAIL");
            $fatal(1, "data_to_mapper mismatch");
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0) begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                $display("Timed out waiting for the reset release");
                $display("TEST FAIL");
                $fatal(1, "Reset timeout");
            end
        end
    endtask

    // Drives one cycle and checks the result of the previous one
    task automatic drive_cycle(input cpu_bus_t c, input dev_sel_t s);
        @(posedge clk);
        cpu <= c;
        sel <= s;
        @(negedge clk);
        if (expect_valid) begin
            check_segment(expected, data_to_mapper);
        end
        expected     = predict(s, c.addr);
        expect_valid = 1'b1;
        model_bus(c);
    endtask

    task automatic read_windows(input dev_sel_t s);
        logic [31:0] r;
        for (int w = 0; w < 4; w++) begin
            r = rand_bits();
            drive_cycle(make_bus({3'(w + 2), r[12:0]}, r[20:13], 1'b0, 1'b0, 1'b0, 1'b1), s);
        end
    endtask

    task automatic read_all_slots();
        for (int s = 0; s < `ZEMINA_SLOTS; s++) begin
            read_windows(zemina_sel(slot_num_t'(s)));
        end
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] value,
                            input logic iorq, input logic m1, input logic req);
        logic [31:0] r;
        r = rand_bits();
        drive_cycle(make_bus({r[15:8], port}, value, 1'b1, iorq, m1, req), sel);
    endtask

    // Zemina entries at 2, 7 and 12, foreign types elsewhere, some on the same ports
    task automatic build_table();
        for (int e = 0; e < `IO_TABLE_SIZE; e++) begin
            if (e % 5 == 2) begin
                io_table[e] <= '{typ: DEV_ZEMINA90, num: slot_num_t'(e / 5),
                                 port: 8'h77 + 8'(e / 5), mask: 8'hFF};
                slot_port[slot_num_t'(e / 5)] = 8'h77 + 8'(e / 5);
            end else begin
                io_table[e] <= '{typ: dev_type_t'(e % 8), num: slot_num_t'(e % 4),
                                 port: 8'h70 + 8'(e), mask: (e == 15) ? 8'h00 : 8'hFF};
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        cpu_bus_t    c;
        dev_sel_t    s;
        slot_num_t   n;
        lcg_state    = 32'd20522;
        expect_valid = 1'b0;
        reset        <= 1'b1;
        cpu          <= make_bus(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
        sel          <= zemina_sel(2'd0);
        build_table();
        for (int k = 0; k < `ZEMINA_SLOTS; k++) begin
            model_seg[slot_num_t'(k)][0] = 8'd0;
            model_seg[slot_num_t'(k)][1] = 8'd1;
            model_seg[slot_num_t'(k)][2] = 8'd0;
            model_seg[slot_num_t'(k)][3] = 8'd1;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        check_segment(8'hFF, data_to_mapper);  // Idle value while in reset
        reset <= 1'b0;
        wait_reset_release();

        read_windows(zemina_sel(2'd0));
        read_all_slots();

        // All four modes on random slots
        for (int k = 0; k < 48; k++) begin
            r = rand_bits();
            n = slot_num_t'(r[7:0] % 8'd3);
            io_write(slot_port[n], {2'(k), r[29:24]}, 1'b1, 1'b0, 1'b1);
            read_all_slots();
        end

        // Writes that must not reach any slot
        for (int k = 0; k < 12; k++) begin
            r = rand_bits();
            n = slot_num_t'(r[7:0] % 8'd3);
            case (k % 4)
                0: io_write(slot_port[n], r[31:24], 1'b1, 1'b1, 1'b1);  // M1 cycle
                1: io_write(slot_port[n], r[31:24], 1'b0, 1'b0, 1'b1);  // Memory write
                2: io_write(slot_port[n], r[31:24], 1'b1, 1'b0, 1'b0);
                default: io_write(8'h7A + {6'd0, r[9:8]}, r[31:24], 1'b1, 1'b0, 1'b1);
            endcase
            read_all_slots();
        end

        // Foreign device types and the missing slot 3
        for (int t = 0; t < 16; t++) begin
            s = '{typ: dev_type_t'(t), num: slot_num_t'(t % 3)};
            if (s.typ != DEV_ZEMINA90) begin
                read_windows(s);
            end
        end
        read_windows('{typ: DEV_ZEMINA90, num: 2'd3});

        for (int k = 0; k < MIX_CYCLES; k++) begin
            r = rand_bits();
            c = make_bus(r[31:16], r[15:8], r[0] | r[1], r[2] | r[3], r[4] & r[5],
                         ~(r[6] & r[7]));
            r = rand_bits();
            if (r[31:30] != 2'b00) begin
                c.addr[7:0] = 8'h76 + {6'd0, r[29:28]};  // 0x76 sits just below the slots
            end
            if (r[27:24] < 4'd11) begin
                s = zemina_sel(r[23:22]);
            end else begin
                s = '{typ: dev_type_t'(r[21:18]), num: r[17:16]};
            end
            drive_cycle(c, s);
        end
        drive_cycle(make_bus(16'h4000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1), zemina_sel(2'd0));

        if (dut_i.assertions_i.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("%0d assertion failures seen", dut_i.assertions_i.fail_count);
            $display("TEST FAIL");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

//--- verilog.f
+incdir+verilog
verilog/mapper_pkg.sv
verilog/io_port_decoder.sv
verilog/zemina90_slot.sv
verilog/segment_select.sv
verilog/zemina90_top.sv
testbench/zemina90_assertions.sv
testbench/zemina90_tb.sv

//--- verilog/io_port_decoder.sv
`timescale 1ns/1ps
`include "mapper_defines.svh"

module io_port_decoder (
    input  mapper_pkg::cpu_bus_t     cpu,
    input  mapper_pkg::io_entry_t    io_table [`IO_TABLE_SIZE],
    output logic [`ZEMINA_SLOTS-1:0] slot_wr
);

    import mapper_pkg::*;

    logic                      io_write;                  // Qualified I/O write cycle
    logic [`IO_TABLE_SIZE-1:0] entry_hit;                 // Entries matching this port
    logic [`ZEMINA_SLOTS-1:0]  slot_hit;                  // Slots named by a matching entry

    // Only a requested I/O write outside an M1 cycle may reach a slot
    assign io_write = cpu.req && cpu.iorq && cpu.wr && !cpu.m1;

    // Only the bits set in the entry mask take part in the port compare
    always_comb begin
        for (int e = 0; e < `IO_TABLE_SIZE; e++) begin
            entry_hit[e] = (io_table[e].typ == DEV_ZEMINA90) &&
                           (((cpu.addr[7:0] ^ io_table[e].port) & io_table[e].mask) == 8'h00);
        end
    end

    // Fold the entry matches into one enable per slot
    always_comb begin
        slot_hit = '0;
        for (int e = 0; e < `IO_TABLE_SIZE; e++) begin
            for (int s = 0; s < `ZEMINA_SLOTS; s++) begin
                if (entry_hit[e] && io_table[e].num == slot_num_t'(s)) begin
                    slot_hit[s] = 1'b1;
                end
            end
        end
    end

    // Entries naming a slot beyond ZEMINA_SLOTS drop out here

    // Single-cycle strobe without back-pressure
    assign slot_wr = io_write ? slot_hit : '0;

endmodule

//--- verilog/mapper_defines.svh
`ifndef MAPPER_DEFINES_SVH
`define MAPPER_DEFINES_SVH

// Build-time sizes of the Zemina 90-in-1 bank-switching unit

// Number of cartridge instances running side by side
// The slot index type is 2 bits wide, so at most four fit
`define ZEMINA_SLOTS 3

// Entries in the I/O port table
// Each entry maps a port and mask onto one device type and slot
`define IO_TABLE_SIZE 16

// Writes hit the I/O space through address bits 7:0 only

`endif

//--- verilog/mapper_pkg.sv
package mapper_pkg;

    // Widths that carry a meaning on the cartridge bus
    typedef logic [7:0] segment_t;    // 8 KB segment number
    typedef logic [1:0] bank_mode_t;  // Value bits 7:6 of an I/O write
    typedef logic [1:0] slot_num_t;   // Cartridge instance index
    typedef logic [3:0] dev_type_t;   // Device type code in the port table

    // Device type code of this mapper
    localparam dev_type_t DEV_ZEMINA90 = 4'h9;

    // One CPU bus cycle as seen by the unit
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        wr;    // Write cycle
        logic        iorq;  // I/O request
        logic        m1;    // Opcode fetch or interrupt acknowledge
        logic        req;   // Bus request qualifier
    } cpu_bus_t;

    // One entry of the I/O port table
    typedef struct packed {
        dev_type_t   typ;
        slot_num_t   num;
        logic [7:0]  port;
        logic [7:0]  mask;  // Set bits must match the port
    } io_entry_t;

    // Device the memory system currently addresses
    typedef struct packed {
        dev_type_t   typ;
        slot_num_t   num;
    } dev_sel_t;

endpackage

//--- verilog/segment_select.sv
`timescale 1ns/1ps
`include "mapper_defines.svh"

module segment_select (
    input  logic                 clk,
    input  logic                 reset,
    input  mapper_pkg::dev_sel_t sel,
    input  mapper_pkg::segment_t slot_segment [`ZEMINA_SLOTS],
    output mapper_pkg::segment_t data_to_mapper
);

    import mapper_pkg::*;

    segment_t next_segment;  // Value taken at the next edge

    // Anything but an existing Zemina slot reads as 0xFF
    always_comb begin
        next_segment = 8'hFF;
        if (sel.typ == DEV_ZEMINA90) begin
            for (int s = 0; s < `ZEMINA_SLOTS; s++) begin
                if (sel.num == slot_num_t'(s)) begin
                    next_segment = slot_segment[s];
                end
            end
        end
    end

    // One cycle of latency from address and selection
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_to_mapper <= 8'hFF;
        end else begin
            data_to_mapper <= next_segment;
        end
    end

endmodule

//--- verilog/zemina90_slot.sv
`timescale 1ns/1ps

module zemina90_slot (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr,
    input  logic [7:0]          data,
    input  logic [15:0]         addr,
    output mapper_pkg::segment_t segment
);

    import mapper_pkg::*;

    segment_t   seg_reg [0:3];  // One register per 8 KB window
    segment_t   page;
    segment_t   page_lo;        // Page with bit 1 cleared
    segment_t   page_hi;        // Page with bit 1 set
    bank_mode_t mode;
    logic [1:0] win_idx;

    // Value bits 5:0 give a 16 KB page, doubled into 8 KB segments
    assign page    = {1'b0, data[5:0], 1'b0};
    assign page_lo = page & ~8'h02;
    assign page_hi = page | 8'h02;
    assign mode    = data[7:6];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            seg_reg[0] <= 8'd0;
            seg_reg[1] <= 8'd1;
            seg_reg[2] <= 8'd0;
            seg_reg[3] <= 8'd1;
        end else if (wr) begin
            case (mode)
                2'b00, 2'b01: begin  // Same 16 KB page mirrored twice
                    seg_reg[0] <= page;
                    seg_reg[1] <= page + 8'd1;
                    seg_reg[2] <= page;
                    seg_reg[3] <= page + 8'd1;
                end
                2'b10: begin  // 32 KB block of an even and an odd 16 KB page
                    seg_reg[0] <= page_lo;
                    seg_reg[1] <= page_lo + 8'd1;
                    seg_reg[2] <= page_hi;
                    seg_reg[3] <= page_hi + 8'd1;
                end
                2'b11: begin
                    // Upper window pair in reverse order
                    seg_reg[0] <= page;
                    seg_reg[1] <= page + 8'd1;
                    seg_reg[2] <= page + 8'd1;
                    seg_reg[3] <= page;
                end
            endcase
        end
    end

    // Window index relative to 0x4000 wraps outside the banked range
    assign win_idx = addr[14:13] - 2'd2;
    assign segment = seg_reg[win_idx];

endmodule

//--- verilog/zemina90_top.sv
`timescale 1ns/1ps
`include "mapper_defines.svh"

module zemina90_top (
    input  logic                  clk,
    input  logic                  reset,
    input  mapper_pkg::cpu_bus_t  cpu,
    input  mapper_pkg::io_entry_t io_table [`IO_TABLE_SIZE],
    input  mapper_pkg::dev_sel_t  sel,
    output mapper_pkg::segment_t  data_to_mapper
);

    import mapper_pkg::*;

    logic [`ZEMINA_SLOTS-1:0] slot_wr;                       // Per-slot I/O write strobe
    segment_t                 slot_segment [`ZEMINA_SLOTS];  // Window segment of each slot

    // Port table lookup
    io_port_decoder io_port_decoder_i (
        .cpu      (cpu),
        .io_table (io_table),
        .slot_wr  (slot_wr)
    );

    // Cartridge instances share the data byte and the address
    genvar i;
    generate
        for (i = 0; i < `ZEMINA_SLOTS; i++) begin : slot_gen
            zemina90_slot zemina90_slot_i (
                .clk     (clk),
                .reset   (reset),
                .wr      (slot_wr[i]),
                .data    (cpu.data),
                .addr    (cpu.addr),
                .segment (slot_segment[i])
            );
        end
    endgenerate

    // Registered output toward the memory system
    segment_select segment_select_i (
        .clk            (clk),
        .reset          (reset),
        .sel            (sel),
        .slot_segment   (slot_segment),
        .data_to_mapper (data_to_mapper)
    );

endmodule
